/* mem_trace.txt */
# name kind width unsigned addr wdata expect   (addr, wdata and expect in hex)
# kind is store, load, uart or counter; width is b, h or w; expect unused for stores
sw_a       store   w 0 00000010 a5c31e7f 00000000
lw_a       load    w 0 00000010 00000000 a5c31e7f
sw_b       store   w 0 00000020 01234567 00000000
lw_b       load    w 0 00000020 00000000 01234567
cnt_first  counter w 0 ffffff00 00000000 00000000
sw_c       store   w 0 00000030 11223344 00000000
sb_c0      store   b 0 00000030 7e5a90aa 00000000
lw_c0      load    w 0 00000030 00000000 112233aa
sb_c1      store   b 0 00000031 123456bb 00000000
lw_c1      load    w 0 00000030 00000000 1122bbaa
sb_c2      store   b 0 00000032 fedcbacc 00000000
lw_c2      load    w 0 00000030 00000000 11ccbbaa
sb_c3      store   b 0 00000033 000000dd 00000000
lw_c3      load    w 0 00000030 00000000 ddccbbaa
sw_d       store   w 0 00000040 55667788 00000000
sh_d0      store   h 0 00000040 dead8001 00000000
lw_d0      load    w 0 00000040 00000000 55668001
sh_d2      store   h 0 00000042 0000f00d 00000000
lw_d2      load    w 0 00000040 00000000 f00d8001
lb_d0      load    b 0 00000040 00000000 00000001
lb_d1      load    b 0 00000041 00000000 ffffff80
lbu_d1     load    b 1 00000041 00000000 00000080
lb_d2      load    b 0 00000042 00000000 0000000d
lb_d3      load    b 0 00000043 00000000 fffffff0
lbu_d3     load    b 1 00000043 00000000 000000f0
lh_d0      load    h 0 00000040 00000000 ffff8001
lhu_d0     load    h 1 00000040 00000000 00008001
lh_d2      load    h 0 00000042 00000000 fffff00d
lhu_d2     load    h 1 00000042 00000000 0000f00d
cnt_mid    counter w 0 ffffff00 00000000 00000000
lb_c2      load    b 0 00000032 00000000 ffffffcc
lbu_c0     load    b 1 00000030 00000000 000000aa
lh_c2      load    h 0 00000032 00000000 ffffddcc
lhu_c0     load    h 1 00000030 00000000 0000bbaa
sw_e       store   w 0 00000050 7fff1234 00000000
lh_e2      load    h 0 00000052 00000000 00007fff
lb_e0      load    b 0 00000050 00000000 00000034
sw_u       store   w 0 00000304 12345678 00000000
uart_0     uart    b 0 ffffff04 0000005a 0000005a
lw_uart    load    w 0 ffffff04 00000000 12345678
lw_u       load    w 0 00000304 00000000 12345678
uart_1     uart    b 0 ffffff04 9abcdec3 000000c3
cnt_last   counter w 0 ffffff00 00000000 00000000

/* list.f */
mem_pkg.sv
store_align.sv
data_ram.sv
mmio_regs.sv
load_extract.sv
memory_access.sv
tb_memory_access.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP   = tb_memory_access
FLIST = list.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | awk '{ print } /^Finished with no errors$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* tb_memory_access.sv */
`default_nettype none

module tb_memory_access;
  timeunit 1ns;
  timeprecision 100ps;

  import mem_pkg::*;

  localparam int CLK_PERIOD = 20;

  logic       clk;
  logic       rst;
  logic       in_valid;
  word_t      pc;
  logic       irreg_pc;
  word_t      alu_result;
  logic       is_load;
  logic       is_store;
  logic       is_load_unsigned;
  mem_width_t mem_width;
  word_t      w_data;
  reg_addr_t  rd_addr;
  logic       reg_we;
  logic       wb_valid;
  word_t      wb_pc;
  logic       wb_irreg_pc;
  word_t      wb_r_data;
  word_t      wb_alu_result;
  logic       wb_is_load;
  logic       wb_reg_we;
  reg_addr_t  wb_rd_addr;
  logic [7:0] uart;
  logic       uart_we;

  integer seed;
  int     errors;
  int     limit;
  int     cycles;
  time    release_time; // Reset release, counter is 0 from here
  word_t  prev_hc_val;
  time    prev_hc_time;
  logic   have_prev_hc;

  // Trace contents, one entry per access
  string      t_name[$];
  string      t_kind[$];
  mem_width_t t_width[$];
  logic       t_uns[$];
  word_t      t_addr[$];
  word_t      t_wdata[$];
  word_t      t_exp[$];

  memory_access dut (
    .clk              (clk),
    .rst              (rst),
    .in_valid         (in_valid),
    .pc               (pc),
    .irreg_pc         (irreg_pc),
    .alu_result       (alu_result),
    .is_load          (is_load),
    .is_store         (is_store),
    .is_load_unsigned (is_load_unsigned),
    .mem_width        (mem_width),
    .w_data           (w_data),
    .rd_addr          (rd_addr),
    .reg_we           (reg_we),
    .wb_valid         (wb_valid),
    .wb_pc            (wb_pc),
    .wb_irreg_pc      (wb_irreg_pc),
    .wb_r_data        (wb_r_data),
    .wb_alu_result    (wb_alu_result),
    .wb_is_load       (wb_is_load),
    .wb_reg_we        (wb_reg_we),
    .wb_rd_addr       (wb_rd_addr),
    .uart             (uart),
    .uart_we          (uart_we)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: no result after %0d cycles", cycles);
      $display("Finished with errors");
      $fatal(1, "run aborted by timeout");
    end
  end

  task automatic stop_on_error(input string msg);
    errors++;
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_uart(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s: expected uart %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_ctl(input string name, input logic exp_we, input reg_addr_t exp_rd,
                           input logic exp_ld, input logic exp_irreg, input logic act_we,
                           input reg_addr_t act_rd, input logic act_ld, input logic act_irreg);
    if (act_we !== exp_we || act_rd !== exp_rd || act_ld !== exp_ld ||
        act_irreg !== exp_irreg) begin
      stop_on_error($sformatf(
        "FAIL %s: expected we=%b rd=%0d load=%b irreg=%b, actual we=%b rd=%0d load=%b irreg=%b",
        name, exp_we, exp_rd, exp_ld, exp_irreg, act_we, act_rd, act_ld, act_irreg));
    end
  endtask

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic logic rand_bit();
    word_t r;
    r = $random(seed);
    return r[0];
  endfunction

  task automatic drive_idle();
    word_t r;
    r                = rand_word();
    in_valid         = 1'b0;
    pc               = rand_word();
    irreg_pc         = rand_bit();
    alu_result       = rand_word();
    is_load          = 1'b0;
    is_store         = 1'b0;
    is_load_unsigned = rand_bit();
    mem_width        = MEM_WORD;
    w_data           = rand_word();
    rd_addr          = r[4:0];
    reg_we           = rand_bit();
  endtask

  task automatic read_trace();
    int    fd;
    int    n;
    int    uns_i;
    string line_s;
    string name_s;
    string kind_s;
    string width_s;
    word_t a;
    word_t d;
    word_t e;
    fd = $fopen("mem_trace.txt", "r");
    if (fd == 0) begin
      stop_on_error("Could not open mem_trace.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line_s, fd);
      if (n == 0) break;
      if (line_s[0] == "#") continue;
      n = $sscanf(line_s, "%s %s %s %d %h %h %h", name_s, kind_s, width_s, uns_i, a, d, e);
      if (n <= 0) continue; // Blank line
      if (n != 7) stop_on_error($sformatf("Malformed trace line: %s", line_s));
      if (kind_s != "store" && kind_s != "load" && kind_s != "uart" && kind_s != "counter") begin
        stop_on_error($sformatf("Unknown access kind %s in trace", kind_s));
      end
      case (width_s)
        "b":     t_width.push_back(MEM_BYTE);
        "h":     t_width.push_back(MEM_HALF);
        "w":     t_width.push_back(MEM_WORD);
        default: stop_on_error($sformatf("Unknown width %s in trace", width_s));
      endcase
      t_name.push_back(name_s);
      t_kind.push_back(kind_s);
      t_uns.push_back(uns_i != 0);
      t_addr.push_back(a);
      t_wdata.push_back(d);
      t_exp.push_back(e);
    end
    $fclose(fd);
    limit = 8 + 2 * t_name.size() + 20;
  endtask

  // One access, then a bubble while the write-back register is checked
  task automatic run_line(input int i);
    string     name;
    string     kind;
    word_t     exp_pc;
    word_t     r;
    reg_addr_t exp_rd;
    logic      exp_we;
    logic      exp_ld;
    logic      exp_irreg;
    time       t_drive;
    word_t     hc_at_drive;
    word_t     exp_val;
    name      = t_name[i];
    kind      = t_kind[i];
    exp_val   = t_exp[i];
    exp_pc    = rand_word();
    r         = rand_word();
    exp_rd    = r[4:0];
    exp_we    = rand_bit();
    exp_irreg = rand_bit();
    exp_ld    = (kind == "load") || (kind == "counter");

    in_valid         = 1'b1;
    pc               = exp_pc;
    irreg_pc         = exp_irreg;
    alu_result       = t_addr[i];
    is_load          = exp_ld;
    is_store         = (kind == "store") || (kind == "uart");
    is_load_unsigned = t_uns[i];
    mem_width        = t_width[i];
    w_data           = t_wdata[i];
    rd_addr          = exp_rd;
    reg_we           = exp_we;
    t_drive          = $time;
    hc_at_drive      = word_t'((t_drive - release_time) / CLK_PERIOD);

    @(posedge clk);
    #2;
    drive_idle();
    @(negedge clk);
    if (wb_valid !== 1'b1) begin
      stop_on_error($sformatf("wb_valid not set one cycle after access %s", name));
    end

    check_word($sformatf("%s_pc", name), exp_pc, wb_pc);
    check_word($sformatf("%s_alu", name), t_addr[i], wb_alu_result);
    check_ctl(name, exp_we, exp_rd, exp_ld, exp_irreg,
              wb_reg_we, wb_rd_addr, wb_is_load, wb_irreg_pc);

    if (kind == "load") begin
      check_word(name, exp_val, wb_r_data);
    end else if (kind == "counter") begin
      if (have_prev_hc) begin
        check_word($sformatf("%s_gap", name),
                   word_t'((t_drive - prev_hc_time) / CLK_PERIOD),
                   wb_r_data - prev_hc_val);
      end
      check_word(name, hc_at_drive, wb_r_data);
      prev_hc_val  = wb_r_data;
      prev_hc_time = t_drive;
      have_prev_hc = 1'b1;
    end

    if (kind == "uart") begin
      if (uart_we !== 1'b1) stop_on_error("uart_we did not pulse after a UART store");
      check_uart(name, exp_val[7:0], uart);
      @(negedge clk);
      if (uart_we !== 1'b0) stop_on_error("uart_we stayed high for more than one cycle");
    end else if (uart_we !== 1'b0) begin
      stop_on_error("uart_we went high without a UART store");
    end

    @(posedge clk);
    #2;
    // Bubble must not reach write-back as valid
    if (wb_valid !== 1'b0 || wb_reg_we !== 1'b0 || wb_is_load !== 1'b0) begin
      stop_on_error($sformatf("Write-back control set by the bubble after %s", name));
    end
  endtask

  initial begin
    seed         = 50364;
    errors       = 0;
    limit        = 0;
    cycles       = 0;
    have_prev_hc = 1'b0;
    clk          = 1'b0;
    rst          = 1'b1;
    drive_idle();
    read_trace();

    repeat (8) @(posedge clk);
    #2;
    rst          = 1'b0;
    release_time = $time;
    if (wb_valid !== 1'b0 || wb_reg_we !== 1'b0 || wb_is_load !== 1'b0 ||
        uart_we !== 1'b0) begin
      stop_on_error("Control outputs not cleared by reset");
    end

    for (int i = 0; i < t_name.size(); i++) begin
      run_line(i);
    end

    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* memory_access.sv */
`default_nettype none

module memory_access #(
  parameter int             RAM_WORDS = 256,
  parameter mem_pkg::word_t HC_ADDR   = 32'hFFFF_FF00,
  parameter mem_pkg::word_t UART_ADDR = 32'hFFFF_FF04
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       in_valid,
  input  wire mem_pkg::word_t       pc,
  input  wire                       irreg_pc,
  input  wire mem_pkg::word_t       alu_result,
  input  wire                       is_load,
  input  wire                       is_store,
  input  wire                       is_load_unsigned,
  input  wire mem_pkg::mem_width_t  mem_width,
  input  wire mem_pkg::word_t       w_data,
  input  wire mem_pkg::reg_addr_t   rd_addr,
  input  wire                       reg_we,
  output logic                      wb_valid,
  output mem_pkg::word_t            wb_pc,
  output logic                      wb_irreg_pc,
  output mem_pkg::word_t            wb_r_data,
  output mem_pkg::word_t            wb_alu_result,
  output logic                      wb_is_load,
  output logic                      wb_reg_we,
  output mem_pkg::reg_addr_t        wb_rd_addr,
  output logic [7:0]                uart,
  output logic                      uart_we
);
  import mem_pkg::*;

  localparam int LINE_W = $clog2(RAM_WORDS);

  logic [LINE_W-1:0] line;
  logic [1:0]        offset;
  byte_en_t          byte_en;
  word_t             shifted_w_data;
  logic              uart_sel;
  logic [7:0]        uart_byte;
  logic              hc_sel;
  word_t             hc_count;
  word_t             row_r_data;
  word_t             r_data;

  store_align #(
    .RAM_WORDS (RAM_WORDS),
    .HC_ADDR   (HC_ADDR),
    .UART_ADDR (UART_ADDR)
  ) u_store_align (
    .in_valid       (in_valid),
    .is_store       (is_store),
    .is_load        (is_load),
    .addr           (alu_result),
    .mem_width      (mem_width),
    .w_data         (w_data),
    .line           (line),
    .offset         (offset),
    .byte_en        (byte_en),
    .shifted_w_data (shifted_w_data),
    .uart_sel       (uart_sel),
    .uart_byte      (uart_byte),
    .hc_sel         (hc_sel)
  );

  data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_data_ram (
    .clk     (clk),
    .line    (line),
    .byte_en (byte_en),
    .w_data  (shifted_w_data),
    .r_data  (row_r_data)
  );

  mmio_regs u_mmio_regs (
    .clk       (clk),
    .rst       (rst),
    .uart_sel  (uart_sel),
    .uart_byte (uart_byte),
    .hc_count  (hc_count),
    .uart      (uart),
    .uart_we   (uart_we)
  );

  load_extract u_load_extract (
    .row_r_data       (row_r_data),
    .hc_count         (hc_count),
    .hc_sel           (hc_sel),
    .mem_width        (mem_width),
    .is_load_unsigned (is_load_unsigned),
    .offset           (offset),
    .r_data           (r_data)
  );

  // Write-back register, control part
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid   <= 1'b0;
      wb_reg_we  <= 1'b0;
      wb_is_load <= 1'b0;
    end else begin
      wb_valid   <= in_valid;
      wb_reg_we  <= in_valid && reg_we; // No write for a bubble
      wb_is_load <= in_valid && is_load;
    end
  end

  // Payload loaded every cycle
  always_ff @(posedge clk) begin
    wb_pc         <= pc;
    wb_irreg_pc   <= irreg_pc;
    wb_r_data     <= r_data;
    wb_alu_result <= alu_result;
    wb_rd_addr    <= rd_addr;
  end

endmodule

`default_nettype wire

/* load_extract.sv */
`default_nettype none

module load_extract (
  input  wire mem_pkg::word_t       row_r_data,
  input  wire mem_pkg::word_t       hc_count,
  input  wire                       hc_sel,
  input  wire mem_pkg::mem_width_t  mem_width,
  input  wire                       is_load_unsigned,
  input  wire [1:0]                 offset,
  output mem_pkg::word_t            r_data
);
  import mem_pkg::*;

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;
  logic        fill;

  assign lane_byte = row_r_data[offset*8 +: 8];
  assign lane_half = row_r_data[offset[1]*16 +: 16]; // Aligned halves only

  always_comb begin
    fill = 1'b0;
    if (hc_sel) begin
      r_data = hc_count;
    end else begin
      case (mem_width)
        MEM_BYTE: begin
          fill   = !is_load_unsigned && lane_byte[7];
          r_data = {{24{fill}}, lane_byte};
        end
        MEM_HALF: begin
          fill   = !is_load_unsigned && lane_half[15];
          r_data = {{16{fill}}, lane_half};
        end
        default: r_data = row_r_data;
      endcase
    end
  end

endmodule

`default_nettype wire

/* mmio_regs.sv */
`default_nettype none

module mmio_regs (
  input  wire             clk,
  input  wire             rst,
  input  wire             uart_sel,
  input  wire [7:0]       uart_byte,
  output mem_pkg::word_t  hc_count,
  output logic [7:0]      uart,
  output logic            uart_we
);

  // Free-running cycle counter
  always_ff @(posedge clk) begin
    if (rst) begin
      hc_count <= '0;
    end else begin
      hc_count <= hc_count + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      uart_we <= 1'b0;
    end else begin
      uart_we <= uart_sel; // One-cycle strobe per UART store
    end
  end

  // Byte holds until the next UART store
  always_ff @(posedge clk) begin
    if (uart_sel) begin
      uart <= uart_byte;
    end
  end

  // UART data must be known when it is written
  a_uart_byte_known: assert property (@(posedge clk) disable iff (rst)
    uart_sel |-> !$isunknown(uart_byte))
    else $error("UART store with unknown data");

endmodule

`default_nettype wire

/* data_ram.sv */
`default_nettype none

module data_ram #(
  parameter int RAM_WORDS = 256
) (
  input  wire                          clk,
  input  wire [$clog2(RAM_WORDS)-1:0]  line,
  input  wire mem_pkg::byte_en_t       byte_en,
  input  wire mem_pkg::word_t          w_data,
  output mem_pkg::word_t               r_data
);
  import mem_pkg::*;

  word_t mem [RAM_WORDS];

  // Byte lanes written independently
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (byte_en[i]) begin
        mem[line][i*8 +: 8] <= w_data[i*8 +: 8];
      end
    end
  end

  assign r_data = mem[line]; // Async read, same cycle as address

endmodule

`default_nettype wire

/* store_align.sv */
`default_nettype none

module store_align #(
  parameter int             RAM_WORDS = 256,
  parameter mem_pkg::word_t HC_ADDR   = 32'hFFFF_FF00,
  parameter mem_pkg::word_t UART_ADDR = 32'hFFFF_FF04
) (
  input  wire                             in_valid,
  input  wire                             is_store,
  input  wire                             is_load,
  input  wire mem_pkg::word_t             addr,
  input  wire mem_pkg::mem_width_t        mem_width,
  input  wire mem_pkg::word_t             w_data,
  output logic [$clog2(RAM_WORDS)-1:0]    line,
  output logic [1:0]                      offset,
  output mem_pkg::byte_en_t               byte_en,
  output mem_pkg::word_t                  shifted_w_data,
  output logic                            uart_sel,
  output logic [7:0]                      uart_byte,
  output logic                            hc_sel
);
  import mem_pkg::*;

  localparam int LINE_W = $clog2(RAM_WORDS);

  byte_en_t lane_mask;
  logic     mmio_hit;

  assign offset = addr[1:0];
  assign line   = addr[LINE_W+1:2]; // Word index, upper bits wrap

  assign mmio_hit  = (addr == HC_ADDR) || (addr == UART_ADDR);
  assign hc_sel    = in_valid && is_load && (addr == HC_ADDR);
  assign uart_sel  = in_valid && is_store && (mem_width == MEM_BYTE) && (addr == UART_ADDR);
  assign uart_byte = w_data[7:0];

  // Move store data up to its lane
  assign shifted_w_data = w_data << {offset, 3'b000};

  always_comb begin
    case (mem_width)
      MEM_BYTE: lane_mask = 4'b0001 << offset;
      MEM_HALF: lane_mask = 4'b0011 << offset;
      default:  lane_mask = 4'b1111;
    endcase
    // MMIO addresses never reach the RAM
    byte_en = (in_valid && is_store && !mmio_hit) ? lane_mask : '0;
  end

  // Execute stage must never issue a misaligned access
  always_comb begin
    if (in_valid && (is_load || is_store)) begin
      assert final ((mem_width != MEM_HALF || !addr[0]) &&
                    (mem_width != MEM_WORD || addr[1:0] == 2'b00))
        else $error("misaligned access at %h", addr);
    end
  end

endmodule

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

  typedef logic [31:0] word_t;     // Data or byte address
  typedef logic [4:0]  reg_addr_t; // Destination register number
  typedef logic [3:0]  byte_en_t;  // One bit per byte lane

  // Access width from the decoder
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_width_t;

endpackage

`default_nettype wire
